// ==== verilog.f ====
verilog/spi_pkg.sv
verilog/spi_master_regs.sv
verilog/spi_master_ctrl.sv
verilog/spi_master_clkgen.sv
verilog/spi_master_shift.sv
verilog/spi_master.sv
tests/spi_master_tb.sv

// ==== Bender.yml ====
package:
  name: spi_master

sources:
  - verilog/spi_pkg.sv
  - verilog/spi_master_regs.sv
  - verilog/spi_master_ctrl.sv
  - verilog/spi_master_clkgen.sv
  - verilog/spi_master_shift.sv
  - verilog/spi_master.sv
  - target: test
    files:
      - tests/spi_master_tb.sv

// ==== tests/spi_master_tb.sv ====
// spi master directed testbench
`timescale 1ns/1ps
`default_nettype none

module spi_master_tb;

   logic                      clk;
   logic                      nreset;
   logic                      packet_in_valid;
   spi_pkg::spi_packet_t      packet_in;
   logic                      packet_out_ready;
   wire                       packet_in_ready;
   wire                       packet_out_valid;
   wire spi_pkg::spi_packet_t packet_out;
   wire                       sclk;
   wire                       mosi;
   wire                       ss_n;
   wire                       irq;
   int                        errors;
   int unsigned               seed_val;
   logic [63:0]               rx_model;   // expected rx register

   // mosi looped straight back into miso
   spi_master spi_master_inst (
      .clk, .nreset,
      .packet_in_valid, .packet_in, .packet_in_ready,
      .packet_out_valid, .packet_out, .packet_out_ready,
      .sclk, .mosi, .miso(mosi), .ss_n, .irq
   );

   always #2 clk = ~clk;   // 4 ns period

   //####################
   // helpers
   //####################
   task automatic abort_on_timeout(input string what);
      $display("timeout while waiting for %s", what);
      errors++;
      $display("errors: %0d", errors);
      $display("Errors found");
      $finish;
   endtask

   task automatic compare(input string name, input logic [63:0] expected,
                          input logic [63:0] actual);
      if (actual !== expected) begin
         $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
         errors++;
      end
   endtask

   task automatic send_packet(input spi_pkg::spi_packet_t pkt);
      int waited;
      waited = 0;
      @(posedge clk);
      packet_in_valid <= 1'b1;
      packet_in       <= pkt;
      @(negedge clk);
      while (!packet_in_ready) begin   // stalled by a pending response
         waited++;
         if (waited > 100) abort_on_timeout("packet_in_ready");
         @(negedge clk);
      end
      @(posedge clk);   // accept edge
      packet_in_valid <= 1'b0;
   endtask

   task automatic write_reg(input spi_pkg::spi_reg_e sel,
                            input spi_pkg::spi_datamode_e dm, input logic [63:0] value);
      spi_pkg::spi_packet_t pkt;
      pkt          = '0;
      pkt.write    = 1'b1;
      pkt.datamode = dm;
      pkt.dstaddr  = {26'd0, sel, 2'b00};
      pkt.srcaddr  = value[63:32];   // high half
      pkt.data     = value[31:0];
      send_packet(pkt);
   endtask

   task automatic read_reg(input spi_pkg::spi_reg_e sel, output logic [63:0] value);
      spi_pkg::spi_packet_t pkt;
      spi_pkg::spi_packet_t resp;
      int waited;
      waited       = 0;
      pkt          = '0;
      pkt.datamode = spi_pkg::dm_dword;
      pkt.dstaddr  = {26'd0, sel, 2'b00};
      pkt.srcaddr  = $urandom;   // return address
      send_packet(pkt);
      @(negedge clk);
      while (!packet_out_valid) begin
         waited++;
         if (waited > 100) abort_on_timeout("read response");
         @(negedge clk);
      end
      resp = packet_out;   // first look at the response
      repeat (3) begin   // back-pressure, response must hold
         @(negedge clk);
         compare("read held valid", 64'd1, packet_out_valid);
         compare("read stall ready", 64'd0, packet_in_ready);
         compare("read held data", {resp.srcaddr, resp.data},
                 {packet_out.srcaddr, packet_out.data});
         compare("read held dstaddr", {32'd0, resp.dstaddr}, {32'd0, packet_out.dstaddr});
      end
      @(posedge clk);
      packet_out_ready <= 1'b1;
      @(posedge clk);   // taken here
      packet_out_ready <= 1'b0;
      compare("read return address", {32'd0, pkt.srcaddr}, {32'd0, resp.dstaddr});
      compare("read response write bit", 64'd0, resp.write);
      value = {resp.srcaddr, resp.data};
   endtask

   task automatic wait_done();
      logic [63:0] status;
      int polls;
      polls = 0;
      read_reg(spi_pkg::reg_status, status);
      while (!status[0]) begin
         polls++;
         if (polls > 500) abort_on_timeout("done flag");
         read_reg(spi_pkg::reg_status, status);
      end
   endtask

   // cmd, then tx bytes 0 up, each byte pushed in at the bottom of rx
   task automatic run_transfer(input string name, input logic [7:0] cmd,
                               input logic [7:0] psize, input logic [63:0] tx,
                               input logic auto_start);
      logic [63:0] value;
      int nbytes;
      nbytes = (psize > 8) ? 8 : psize;
      write_reg(spi_pkg::reg_status, spi_pkg::dm_byte, 64'd0);   // clear done
      write_reg(spi_pkg::reg_cmd, spi_pkg::dm_byte, {56'd0, cmd});
      write_reg(spi_pkg::reg_psize, spi_pkg::dm_byte, {56'd0, psize});
      write_reg(spi_pkg::reg_tx, spi_pkg::dm_dword, tx);   // kicks off in auto mode
      if (!auto_start) begin
         write_reg(spi_pkg::reg_start, spi_pkg::dm_byte, 64'd0);
      end
      wait_done();
      rx_model = {rx_model[55:0], cmd};
      for (int i = 0; i < nbytes; i++) begin
         rx_model = {rx_model[55:0], tx[8*i +: 8]};
      end
      read_reg(spi_pkg::reg_rx, value);
      compare(name, rx_model, value);
      read_reg(spi_pkg::reg_status, value);
      compare({name, " state"}, {62'd0, spi_pkg::st_idle}, {62'd0, value[2:1]});
   endtask

   //####################
   // directed tests
   //####################
   task automatic reset_defaults();
      logic [63:0] value;
      @(negedge clk);
      compare("reset ss_n", 64'd1, ss_n);
      compare("reset sclk", 64'd0, sclk);
      compare("reset irq", 64'd0, irq);
      compare("reset packet_out_valid", 64'd0, packet_out_valid);
      read_reg(spi_pkg::reg_psize, value);
      compare("reset psize", 64'd4, value);
      read_reg(spi_pkg::reg_clkdiv, value);
      compare("reset clkdiv", 64'd3, value);
      read_reg(spi_pkg::reg_config, value);
      compare("reset config", 64'd0, value);
      read_reg(spi_pkg::reg_status, value);
      compare("reset status", 64'd0, value);
   endtask

   task automatic write_masks();
      logic [63:0] tx_model;
      logic [63:0] wval;
      logic [63:0] mask;
      logic [63:0] value;
      int nb;
      tx_model = '0;
      for (int dm = 3; dm >= 0; dm--) begin   // full write first
         wval = {$urandom, $urandom};
         nb   = 1 << dm;   // bytes touched
         mask = (nb == 8) ? 64'hffff_ffff_ffff_ffff : ((64'd1 << (8 * nb)) - 64'd1);
         tx_model = (tx_model & ~mask) | (wval & mask);
         write_reg(spi_pkg::reg_tx, spi_pkg::spi_datamode_e'(dm), wval);
         read_reg(spi_pkg::reg_tx, value);
         compare($sformatf("tx write mask dm %0d", dm), tx_model, value);
      end
   endtask

   task automatic manual_transfer();
      spi_pkg::spi_cfg_t cfg;
      cfg        = '0;
      cfg.spi_en = 1'b1;   // mode 0
      write_reg(spi_pkg::reg_config, spi_pkg::dm_byte, {56'd0, cfg});
      run_transfer("manual start rx", 8'($urandom), 8'd3, {$urandom, $urandom}, 1'b0);
   endtask

   task automatic auto_mode_sweep();
      spi_pkg::spi_cfg_t cfg;
      for (int mode = 0; mode < 4; mode++) begin
         cfg           = '0;
         cfg.spi_en    = 1'b1;
         cfg.auto_mode = 1'b1;
         cfg.cpol      = mode[1];
         cfg.cpha      = mode[0];
         write_reg(spi_pkg::reg_config, spi_pkg::dm_byte, {56'd0, cfg});
         write_reg(spi_pkg::reg_clkdiv, spi_pkg::dm_byte, 64'($urandom % 4));
         run_transfer($sformatf("auto mode %0d rx", mode), 8'($urandom), 8'd7,
                      {$urandom, $urandom}, 1'b1);
         @(negedge clk);
         compare($sformatf("mode %0d idle sclk", mode), {63'd0, cfg.cpol}, sclk);
         compare($sformatf("mode %0d idle ss_n", mode), 64'd1, ss_n);
      end
   endtask

   task automatic enable_and_irq();
      spi_pkg::spi_cfg_t cfg;
      logic [63:0] value;
      cfg        = '0;
      cfg.irq_en = 1'b1;   // spi_en left clear
      write_reg(spi_pkg::reg_config, spi_pkg::dm_byte, {56'd0, cfg});
      write_reg(spi_pkg::reg_status, spi_pkg::dm_byte, 64'd0);
      write_reg(spi_pkg::reg_start, spi_pkg::dm_byte, 64'd0);
      for (int i = 0; i < 40; i++) begin
         @(negedge clk);
         compare("disabled ss_n", 64'd1, ss_n);
      end
      read_reg(spi_pkg::reg_status, value);
      compare("disabled done", 64'd0, value[0]);
      compare("disabled irq", 64'd0, irq);
      cfg.spi_en = 1'b1;
      cfg.irq_en = 1'b0;
      write_reg(spi_pkg::reg_config, spi_pkg::dm_byte, {56'd0, cfg});
      run_transfer("command only rx", 8'($urandom), 8'd0, {$urandom, $urandom}, 1'b0);
      @(negedge clk);
      compare("irq masked", 64'd0, irq);
      cfg.irq_en = 1'b1;
      write_reg(spi_pkg::reg_config, spi_pkg::dm_byte, {56'd0, cfg});
      @(negedge clk);
      compare("irq raised", 64'd1, irq);
      write_reg(spi_pkg::reg_status, spi_pkg::dm_byte, 64'd0);   // sw clear
      @(negedge clk);
      compare("irq cleared", 64'd0, irq);
      read_reg(spi_pkg::reg_status, value);
      compare("done cleared", 64'd0, value[0]);
   endtask

   //####################
   // main sequence
   //####################
   initial begin
      clk              = 1'b0;
      nreset           = 1'b0;
      packet_in_valid  = 1'b0;
      packet_in        = '0;
      packet_out_ready = 1'b0;
      errors           = 0;
      rx_model         = '0;
      seed_val         = $urandom(32'h14bc_5004);
      repeat (5) @(posedge clk);
      nreset <= 1'b1;
      reset_defaults();
      write_masks();
      manual_transfer();
      auto_mode_sweep();
      enable_and_irq();
      $display("errors: %0d", errors);
      if (errors == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== verilog/spi_master.sv ====
// spi master top level
`timescale 1ns/1ps
`default_nettype none

module spi_master (
   input  wire                       clk,
   input  wire                       nreset,
   input  wire                       packet_in_valid,
   input  wire spi_pkg::spi_packet_t packet_in,
   output wire                       packet_in_ready,
   output wire                       packet_out_valid,
   output wire spi_pkg::spi_packet_t packet_out,
   input  wire                       packet_out_ready,
   output wire                       sclk,
   output wire                       mosi,
   input  wire                       miso,
   output wire                       ss_n,
   output wire                       irq
);

   spi_pkg::spi_cfg_t   cfg;
   spi_pkg::spi_state_e state;
   logic                start;
   logic [7:0]          cmd;
   logic [7:0]          psize;
   logic [7:0]          clkdiv;
   logic [63:0]         tx_data;
   logic                run;
   logic                load;
   logic [7:0]          tx_byte;
   logic                lead;
   logic                trail;
   logic                byte_done;
   logic [7:0]          rx_byte;

   spi_master_regs spi_master_regs_inst (
      .clk, .nreset,
      .packet_in_valid, .packet_in, .packet_in_ready,
      .packet_out_valid, .packet_out, .packet_out_ready,
      .state, .byte_done, .rx_byte,
      .start, .cfg, .cmd, .psize, .clkdiv, .tx_data, .irq
   );

   spi_master_ctrl spi_master_ctrl_inst (
      .clk, .nreset, .start, .cfg, .cmd, .psize, .tx_data, .byte_done,
      .state, .run, .load, .ss_n, .tx_byte
   );

   spi_master_clkgen spi_master_clkgen_inst (
      .clk, .nreset, .run, .cpol(cfg.cpol), .clkdiv, .sclk, .lead, .trail
   );

   spi_master_shift spi_master_shift_inst (
      .clk, .nreset, .load, .tx_byte, .lead, .trail, .cpha(cfg.cpha),
      .miso, .mosi, .byte_done, .rx_byte
   );

endmodule

`default_nettype wire

// ==== verilog/spi_master_shift.sv ====
// spi data shifter
`timescale 1ns/1ps
`default_nettype none

module spi_master_shift (
   input  wire       clk,
   input  wire       nreset,
   input  wire       load,
   input  wire [7:0] tx_byte,
   input  wire       lead,
   input  wire       trail,
   input  wire       cpha,
   input  wire       miso,
   output logic      mosi,
   output logic      byte_done,
   output logic [7:0] rx_byte
);

   logic [7:0] tx_sr;     // bits still to drive
   logic [7:0] rx_sr;     // bits sampled so far
   logic [2:0] bit_cnt;   // samples taken in this byte
   logic [7:0] src;
   logic       sample;

   assign sample = cpha ? trail : lead;
   assign src    = load ? tx_byte : tx_sr;   // lead may coincide with load

   // eighth sample completes the byte
   assign byte_done = sample & (bit_cnt == 3'd7);
   assign rx_byte   = {rx_sr[6:0], miso};

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         mosi    <= 1'b0;
         bit_cnt <= 3'd0;
      end else begin
         if (load) begin
            bit_cnt <= 3'd0;
         end else if (sample) begin
            bit_cnt <= bit_cnt + 3'd1;   // wraps to 0 after bit 8
         end
         if (!cpha) begin
            if (load) begin
               mosi <= tx_byte[7];   // first bit ahead of the lead edge
            end else if (trail && (bit_cnt != 3'd0)) begin
               mosi <= tx_sr[7];
            end
         end else if (lead) begin
            mosi <= src[7];
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!cpha && load) begin
         tx_sr <= {tx_byte[6:0], 1'b0};
      end else if (!cpha && trail && (bit_cnt != 3'd0)) begin
         tx_sr <= {tx_sr[6:0], 1'b0};
      end else if (cpha && lead) begin
         tx_sr <= {src[6:0], 1'b0};
      end else if (load) begin
         tx_sr <= tx_byte;   // cpha 1, wait for lead
      end
      if (sample) begin
         rx_sr <= rx_byte;   // msb first
      end
   end

endmodule

`default_nettype wire

// ==== verilog/spi_master_clkgen.sv ====
// spi baud clock generator
`timescale 1ns/1ps
`default_nettype none

module spi_master_clkgen (
   input  wire       clk,
   input  wire       nreset,
   input  wire       run,
   input  wire       cpol,
   input  wire [7:0] clkdiv,
   output logic      sclk,
   output logic      lead,
   output logic      trail
);

   logic [7:0] cnt;   // cycles left in this half period
   logic       tick;

   assign tick = run & (cnt == 8'd0);

   // strobes line up with the cycle where sclk shows its new level
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         cnt   <= 8'd0;
         sclk  <= 1'b0;
         lead  <= 1'b0;
         trail <= 1'b0;
      end else if (!run) begin
         cnt   <= clkdiv;   // full half period before first edge
         sclk  <= cpol;     // idle level
         lead  <= 1'b0;
         trail <= 1'b0;
      end else begin
         lead  <= tick & (sclk == cpol);   // leaving idle level
         trail <= tick & (sclk != cpol);   // back to idle level
         if (tick) begin
            cnt  <= clkdiv;
            sclk <= ~sclk;
         end else begin
            cnt <= cnt - 8'd1;
         end
      end
   end

endmodule

`default_nettype wire

// ==== verilog/spi_master_ctrl.sv ====
// spi transfer sequencer
`timescale 1ns/1ps
`default_nettype none

module spi_master_ctrl (
   input  wire                      clk,
   input  wire                      nreset,
   input  wire                      start,
   input  wire spi_pkg::spi_cfg_t   cfg,
   input  wire [7:0]                cmd,
   input  wire [7:0]                psize,
   input  wire [63:0]               tx_data,
   input  wire                      byte_done,
   output spi_pkg::spi_state_e      state,
   output logic                     run,
   output logic                     load,
   output logic                     ss_n,
   output logic [7:0]               tx_byte
);

   logic [2:0] byte_cnt;    // payload byte index
   logic [3:0] nbytes;      // clamped payload size
   logic       last_byte;

   // anything above one tx register is clipped
   assign nbytes = (psize > 8'(spi_pkg::max_bytes)) ? 4'(spi_pkg::max_bytes) : psize[3:0];
   assign last_byte = ({1'b0, byte_cnt} == (nbytes - 4'd1));

   assign run = (state == spi_pkg::st_cmd) | (state == spi_pkg::st_data);

   // cmd first, then tx bytes from the bottom up
   assign tx_byte = (state == spi_pkg::st_cmd) ? cmd : tx_data[{byte_cnt, 3'b000} +: 8];

   //####################
   // fsm
   //####################
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         state    <= spi_pkg::st_idle;
         byte_cnt <= 3'd0;
         load     <= 1'b0;
         ss_n     <= 1'b1;
      end else begin
         load <= 1'b0;   // single cycle unless set below
         case (state)
            spi_pkg::st_idle: begin
               if (start && cfg.spi_en) begin   // busy starts never reach here
                  state    <= spi_pkg::st_cmd;
                  ss_n     <= 1'b0;
                  load     <= 1'b1;
                  byte_cnt <= 3'd0;
               end
            end
            spi_pkg::st_cmd: begin
               if (byte_done) begin
                  if (nbytes == 4'd0) begin
                     state <= spi_pkg::st_done;   // command only
                  end else begin
                     state <= spi_pkg::st_data;
                     load  <= 1'b1;
                  end
               end
            end
            spi_pkg::st_data: begin
               if (byte_done) begin
                  if (last_byte) begin
                     state <= spi_pkg::st_done;
                  end else begin
                     byte_cnt <= byte_cnt + 3'd1;
                     load     <= 1'b1;
                  end
               end
            end
            default: begin
               state <= spi_pkg::st_idle;   // st_done lasts one cycle
               ss_n  <= 1'b1;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== verilog/spi_master_regs.sv ====
// spi master register file
`timescale 1ns/1ps
`default_nettype none

module spi_master_regs (
   input  wire                       clk,
   input  wire                       nreset,
   input  wire                       packet_in_valid,
   input  wire spi_pkg::spi_packet_t packet_in,
   output logic                      packet_in_ready,
   output logic                      packet_out_valid,
   output spi_pkg::spi_packet_t      packet_out,
   input  wire                       packet_out_ready,
   input  wire spi_pkg::spi_state_e  state,
   input  wire                       byte_done,
   input  wire [7:0]                 rx_byte,
   output logic                      start,
   output spi_pkg::spi_cfg_t         cfg,
   output logic [7:0]                cmd,
   output logic [7:0]                psize,
   output logic [7:0]                clkdiv,
   output logic [63:0]               tx_data,
   output logic                      irq
);

   spi_pkg::spi_reg_e reg_sel;
   logic              accept;
   logic              wr_en;
   logic              rd_en;
   logic [63:0]       wdata;
   logic [63:0]       wmask;
   logic [63:0]       rdata;
   logic [63:0]       rx_data;
   logic              done;

   //####################
   // decode
   //####################
   assign packet_in_ready = ~packet_out_valid;   // stall while a response waits
   assign accept  = packet_in_valid & packet_in_ready;
   assign wr_en   = accept & packet_in.write;
   assign rd_en   = accept & ~packet_in.write;
   assign reg_sel = spi_pkg::spi_reg_e'(packet_in.dstaddr[5:2]);
   assign wdata   = {packet_in.srcaddr, packet_in.data};

   always_comb begin
      case (packet_in.datamode)
         spi_pkg::dm_byte: wmask = 64'h0000_0000_0000_00ff;
         spi_pkg::dm_half: wmask = 64'h0000_0000_0000_ffff;
         spi_pkg::dm_word: wmask = 64'h0000_0000_ffff_ffff;
         default:          wmask = '1;
      endcase
   end

   // start reg always fires, tx only in auto mode
   assign start = wr_en & ((reg_sel == spi_pkg::reg_start) |
                           ((reg_sel == spi_pkg::reg_tx) & cfg.auto_mode));

   //####################
   // registers
   //####################
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         cfg     <= '0;
         cmd     <= 8'h00;
         psize   <= 8'(spi_pkg::psize_default);
         clkdiv  <= 8'(spi_pkg::clkdiv_default);
         tx_data <= '0;
      end else if (wr_en) begin
         case (reg_sel)
            spi_pkg::reg_config: cfg    <= spi_pkg::spi_cfg_t'(wdata[7:0]);
            spi_pkg::reg_cmd:    cmd    <= wdata[7:0];
            spi_pkg::reg_psize:  psize  <= wdata[7:0];
            spi_pkg::reg_clkdiv: clkdiv <= wdata[7:0];
            spi_pkg::reg_tx:     tx_data <= (tx_data & ~wmask) | (wdata & wmask);
            default: ;   // status handled below, start/rx have no storage
         endcase
      end
   end

   // sticky done, set once the transfer wraps up
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         done <= 1'b0;
      end else if (state == spi_pkg::st_done) begin
         done <= 1'b1;
      end else if (wr_en && (reg_sel == spi_pkg::reg_status) && !wdata[0]) begin
         done <= 1'b0;   // sw clear
      end
   end

   // newest byte lands low, older bytes move up
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         rx_data <= '0;
      end else if (byte_done) begin
         rx_data <= {rx_data[55:0], rx_byte};
      end
   end

   assign irq = done & cfg.irq_en;

   //####################
   // readback
   //####################
   always_comb begin
      case (reg_sel)
         spi_pkg::reg_config: rdata = {56'h0, cfg};
         spi_pkg::reg_status: rdata = {61'h0, state, done};
         spi_pkg::reg_cmd:    rdata = {56'h0, cmd};
         spi_pkg::reg_psize:  rdata = {56'h0, psize};
         spi_pkg::reg_clkdiv: rdata = {56'h0, clkdiv};
         spi_pkg::reg_tx:     rdata = tx_data;
         spi_pkg::reg_rx:     rdata = rx_data;
         default:             rdata = '0;   // start reads as zero
      endcase
   end

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         packet_out_valid <= 1'b0;
      end else if (rd_en) begin
         packet_out_valid <= 1'b1;
      end else if (packet_out_ready) begin
         packet_out_valid <= 1'b0;
      end
   end

   // response held until taken, input is stalled meanwhile
   always_ff @(posedge clk) begin
      if (rd_en) begin
         packet_out.write    <= 1'b0;
         packet_out.datamode <= packet_in.datamode;
         packet_out.ctrlmode <= packet_in.ctrlmode;
         packet_out.dstaddr  <= packet_in.srcaddr;   // return address
         packet_out.srcaddr  <= rdata[63:32];
         packet_out.data     <= rdata[31:0];
      end
   end

endmodule

`default_nettype wire

// ==== verilog/spi_pkg.sv ====
// spi master shared types
`default_nettype none

package spi_pkg;

   //####################
   // sizes and defaults
   //####################
   localparam int aw             = 32;   // packet address/data width
   localparam int psize_default  = 4;    // payload bytes after reset
   localparam int clkdiv_default = 3;    // half period = clkdiv+1 clk cycles
   localparam int max_bytes      = 8;    // one 64-bit tx register

   // write size, selects low bytes of the 64-bit write value
   typedef enum logic [1:0] {
      dm_byte  = 2'd0,   // 1 byte
      dm_half  = 2'd1,   // 2 bytes
      dm_word  = 2'd2,   // 4 bytes
      dm_dword = 2'd3    // all 8 bytes
   } spi_datamode_e;

   // mesh style request/response packet, 104 bits
   typedef struct packed {
      logic          write;
      spi_datamode_e datamode;
      logic [4:0]    ctrlmode;   // carried through, not interpreted
      logic [aw-1:0] dstaddr;
      logic [aw-1:0] srcaddr;    // high half of write data
      logic [aw-1:0] data;       // low half of write data
   } spi_packet_t;

   // register index, dstaddr[5:2]
   typedef enum logic [3:0] {
      reg_config = 4'd0,
      reg_status = 4'd1,
      reg_cmd    = 4'd2,
      reg_psize  = 4'd3,
      reg_clkdiv = 4'd4,
      reg_tx     = 4'd5,
      reg_start  = 4'd6,
      reg_rx     = 4'd7
   } spi_reg_e;

   // config register, spi_en sits in bit 0
   typedef struct packed {
      logic [2:0] spare;
      logic       auto_mode;   // tx write starts a transfer
      logic       cpha;
      logic       cpol;
      logic       irq_en;
      logic       spi_en;
   } spi_cfg_t;

   typedef enum logic [1:0] {st_idle, st_cmd, st_data, st_done} spi_state_e;

endpackage

`default_nettype wire
